// ==== pcxt_loader.f ====
source/pcxt_loader_pkg.sv
source/ioctl_decode.sv
source/cpu_clock_select.sv
source/bus_write_sequencer.sv
source/reset_sequencer.sv
source/sound_mixer.sv
source/pcxt_loader_top.sv
sim/pcxt_loader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pcxt_loader testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f pcxt_loader.f \
	--top-module pcxt_loader_tb \
	-Mdir obj_dir \
	-o pcxt_loader_sim

./obj_dir/pcxt_loader_sim > sim.log 2>&1
cat sim.log

if grep -q "^No errors$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// ==== sim/pcxt_loader_tb.sv ====
`timescale 1ns/100ps

module pcxt_loader_tb;

	import pcxt_loader_pkg::*;

	logic               clk_chipset = 1'b0;
	logic               reset_wire;
	logic               download_i;
	logic               ioctl_wr_i;
	ioctl_byte_t        ioctl_i;
	cpu_speed_e         speed_i;
	logic signed [15:0] opl_i;
	logic               speaker_i;
	logic [13:0]        tandy_i;
	logic               ext_access_request_o;
	logic               mem_write_n_o;
	logic [19:0]        bus_addr_o;
	logic [7:0]         bus_data_o;
	logic               sys_reset_o;
	logic               cpu_reset_o;
	logic [15:0]        mix_o;

	int          errors = 0;
	int          checks = 0;
	int          wr_count = 0;
	int          cur_div = 10;
	logic [31:0] rng = 32'h6203_e9a4;
	logic [19:0] got_addr[$];
	logic [7:0]  got_data[$];

	// write cycle monitor state
	logic        wn_prev = 1'b1;
	int          low_len = 0;
	logic [19:0] cap_addr;
	logic [7:0]  cap_data;
	// one cycle delayed references
	logic        dl_q;
	logic [15:0] mix_exp;

	pcxt_loader_top #(
		.RESET_HOLD      (16'd20),
		.CPU_RESET_DELAY (16'd6)
	) pcxt_loader_top_i (
		.clk_chipset          (clk_chipset),
		.reset_wire           (reset_wire),
		.download_i           (download_i),
		.ioctl_wr_i           (ioctl_wr_i),
		.ioctl_i              (ioctl_i),
		.speed_i              (speed_i),
		.opl_i                (opl_i),
		.speaker_i            (speaker_i),
		.tandy_i              (tandy_i),
		.ext_access_request_o (ext_access_request_o),
		.mem_write_n_o        (mem_write_n_o),
		.bus_addr_o           (bus_addr_o),
		.bus_data_o           (bus_data_o),
		.sys_reset_o          (sys_reset_o),
		.cpu_reset_o          (cpu_reset_o),
		.mix_o                (mix_o)
	);

	always #5 clk_chipset = ~clk_chipset;

	//////////////////////////////
	// helpers
	//////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// fm + speaker level + tone x4, kept to 17 bits, then halved
	function automatic logic [15:0] mix_model(input logic [15:0] opl, input logic spk,
		input logic [13:0] tandy);
		int          s;
		logic [16:0] w;
		s = int'($signed(opl)) + (spk ? 0 : 16384) + int'(tandy) * 4;
		w = s[16:0];
		return w[16:1];
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("ERROR %0t %s expected %0h actual %0h", $time, name, exp, act);
		errors++;
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("%s: %0d mismatches", name, errors - errs_before);
	endtask

	// one strobe cycle on the download channel
	task automatic send_byte(input logic [7:0] idx, input logic [24:0] addr,
		input logic [7:0] data);
		@(posedge clk_chipset);
		ioctl_wr_i <= 1'b1;
		ioctl_i    <= '{index: idx, addr: addr, data: data};
		@(posedge clk_chipset);
		ioctl_wr_i <= 1'b0;
	endtask

	task automatic write_expect(input logic [7:0] idx, input logic [24:0] addr,
		input logic [7:0] data, input logic [19:0] exp_addr);
		int          start;
		int          t;
		logic [19:0] ga;
		logic [7:0]  gd;
		start = wr_count;
		send_byte(idx, addr, data);
		t = 0;
		while (wr_count == start && t < 200) begin
			@(posedge clk_chipset);
			t++;
		end
		if (wr_count == start) begin
			$display("timeout: no write cycle for index %0d address %0h", idx, addr);
			errors++;
		end
		else begin
			ga = got_addr.pop_front();
			gd = got_data.pop_front();
			checks += 2;
			assert (ga == exp_addr) else report_mismatch("bus_addr_o", 32'(exp_addr), 32'(ga));
			assert (gd == data) else report_mismatch("bus_data_o", 32'(data), 32'(gd));
		end
	endtask

	// unmapped byte, bus must stay quiet for 60 cycles
	task automatic expect_no_write(input logic [7:0] idx, input logic [24:0] addr);
		int start;
		start = wr_count;
		send_byte(idx, addr, 8'h5A);
		for (int t = 0; t < 60; t++)
			@(posedge clk_chipset);
		checks += 2;
		assert (wr_count == start) else begin
			$display("index %0d address %0h started a write cycle", idx, addr);
			errors++;
		end
		assert (bus_addr_o == 20'hFFFFF)
			else report_mismatch("bus_addr_o", 32'hFFFFF, 32'(bus_addr_o));
	endtask

	//////////////////////////////
	// monitors
	//////////////////////////////

	// catches each low pulse of the write strobe
	always @(posedge clk_chipset) begin
		if (!reset_wire) begin
			if (!mem_write_n_o) begin
				if (wn_prev) begin
					cap_addr = bus_addr_o;
					cap_data = bus_data_o;
					low_len  = 0;
				end
				low_len = low_len + 1;
			end
			else if (!wn_prev) begin
				// pulse over, length bounded by tick phase
				checks++;
				assert (low_len >= (int'(WRITE_TICKS) - 1) * cur_div + 1 &&
					low_len <= int'(WRITE_TICKS) * cur_div) else begin
					$display("ERROR %0t mem_write_n_o low for %0d cycles, divider %0d",
						$time, low_len, cur_div);
					errors++;
				end
				got_addr.push_back(cap_addr);
				got_data.push_back(cap_data);
				wr_count <= wr_count + 1;
			end
			wn_prev = mem_write_n_o;
		end
	end

	// bus claim and mixer, checked every cycle
	always @(posedge clk_chipset) begin
		if (reset_wire) begin
			dl_q    <= 1'b0;
			mix_exp <= 16'd0;
		end
		else begin
			checks += 2;
			assert (ext_access_request_o == dl_q)
				else report_mismatch("ext_access_request_o", 32'(dl_q), 32'(ext_access_request_o));
			assert (mix_o == mix_exp)
				else report_mismatch("mix_o", 32'(mix_exp), 32'(mix_o));
			dl_q    <= download_i;
			mix_exp <= mix_model(opl_i, speaker_i, tandy_i);
		end
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	initial begin
		int          n;
		int          sys_fall;
		int          e0;
		int          start;
		logic [24:0] a;
		logic [1:0]  code;
		int          div_tab[4] = '{10, 7, 3, 10};

		reset_wire = 1'b1;
		download_i = 1'b0;
		ioctl_wr_i = 1'b0;
		ioctl_i    = '0;
		speed_i    = SPEED_4M77;
		opl_i      = '0;
		speaker_i  = 1'b1;
		tandy_i    = '0;
		repeat (2) @(posedge clk_chipset);
		reset_wire <= 1'b0;

		// test 1, reset values then both release points
		e0 = errors;
		checks += 3;
		assert (mem_write_n_o) else report_mismatch("mem_write_n_o", 32'd1, 32'(mem_write_n_o));
		assert (!ext_access_request_o)
			else report_mismatch("ext_access_request_o", 32'd0, 32'(ext_access_request_o));
		assert (mix_o == 16'd0) else report_mismatch("mix_o", 32'd0, 32'(mix_o));
		n = 0;
		sys_fall = 0;
		while (cpu_reset_o && n < 200) begin
			@(posedge clk_chipset);
			n++;
			if (!sys_reset_o && sys_fall == 0)
				sys_fall = n - 1;
		end
		if (cpu_reset_o) begin
			$display("timeout: cpu_reset_o never released");
			errors++;
		end
		checks += 2;
		assert (sys_fall == 20) else report_mismatch("sys_reset_o fall cycle", 32'd20, sys_fall);
		assert (n - 1 - sys_fall == 6)
			else report_mismatch("cpu_reset_o delay", 32'd6, n - 1 - sys_fall);
		report_test("reset timing", e0);
		download_i <= 1'b1;

		// test 2, main bios window, pcxt and tandy images
		e0 = errors;
		for (int k = 0; k < 8; k++) begin
			rng = xorshift(rng);
			a = {9'h0, rng[15:0]};
			write_expect((k % 2 == 1) ? 8'd1 : 8'd0, a, rng[23:16],
				20'hF0000 | {4'h0, a[15:0]});
		end
		report_test("bios window", e0);

		// test 3, disk bios by index 2 or second half of pcxt
		e0 = errors;
		for (int k = 0; k < 4; k++) begin
			rng = xorshift(rng);
			a = rng[24:0];
			write_expect(8'd2, a, rng[31:24], 20'hEC000 | {6'h0, a[13:0]});
			rng = xorshift(rng);
			a = {9'h1, rng[15:0]};
			write_expect(8'd0, a, rng[7:0], 20'hEC000 | {6'h0, a[13:0]});
		end
		expect_no_write(8'd1, {9'h1, 16'h1234});
		expect_no_write(8'd5, 25'h0_0100);
		report_test("disk bios and unmapped", e0);

		// test 4, pulse length at every speed code, 3 falls back to slow
		e0 = errors;
		for (int s = 0; s < 4; s++) begin
			code = 2'(s);
			@(posedge clk_chipset);
			speed_i <= cpu_speed_e'(code);
			cur_div = div_tab[s];
			// old divider period runs out first
			for (int t = 0; t < 25; t++)
				@(posedge clk_chipset);
			for (int k = 0; k < 3; k++) begin
				rng = xorshift(rng);
				a = {9'h0, rng[15:0]};
				write_expect(8'd0, a, rng[31:24], 20'hF0000 | {4'h0, a[15:0]});
			end
		end
		report_test("write duration", e0);

		// test 5, bus claim follows download, busy strobes dropped
		e0 = errors;
		for (int k = 0; k < 8; k++) begin
			@(posedge clk_chipset);
			rng = xorshift(rng);
			download_i <= rng[3];
		end
		download_i <= 1'b1;
		start = wr_count;
		send_byte(8'd0, 25'h0_0010, 8'h11);
		send_byte(8'd0, 25'h0_0020, 8'h22);
		// cycle must finish even with the download gone
		download_i <= 1'b0;
		n = 0;
		while (wr_count == start && n < 200) begin
			@(posedge clk_chipset);
			n++;
		end
		for (int t = 0; t < 60; t++)
			@(posedge clk_chipset);
		checks++;
		assert (wr_count == start + 1) else begin
			$display("expected one write cycle for two close strobes, saw %0d",
				wr_count - start);
			errors++;
		end
		if (got_addr.size() > 0) begin
			checks++;
			assert (got_addr[0] == 20'hF0010)
				else report_mismatch("bus_addr_o", 32'hF0010, 32'(got_addr[0]));
		end
		got_addr.delete();
		got_data.delete();
		download_i <= 1'b1;
		report_test("bus request and busy", e0);

		// test 6, mixer, starts at the most negative fm sample
		e0 = errors;
		for (int k = 0; k < 40; k++) begin
			@(posedge clk_chipset);
			rng = xorshift(rng);
			if (k == 0) begin
				opl_i     <= 16'sh8000;
				speaker_i <= 1'b0;
				tandy_i   <= 14'h3FFF;
			end
			else begin
				opl_i     <= rng[15:0];
				speaker_i <= rng[16];
				tandy_i   <= rng[30:17];
			end
		end
		repeat (3) @(posedge clk_chipset);
		report_test("mixer", e0);

		$display("checks %0d, mismatches %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== source/bus_write_sequencer.sv ====
`timescale 1ns/100ps

module bus_write_sequencer (
	input  logic                       clk_chipset,
	input  logic                       reset_wire,
	input  logic                       download_i,
	input  pcxt_loader_pkg::bus_write_t req_i,
	input  logic                       cpu_tick_i,
	output logic                       ext_access_request_o,
	output logic                       mem_write_n_o,
	output logic [19:0]                bus_addr_o,
	output logic [7:0]                 bus_data_o
);

	import pcxt_loader_pkg::*;

	typedef enum logic {
		ST_IDLE   = 1'b0,
		ST_STROBE = 1'b1
	} seq_state_e;

	seq_state_e  state;
	logic [2:0]  tick_cnt;
	logic        last_tick;

	logic        ext_req_q;
	logic        write_n_q;
	logic [19:0] addr_q;
	logic [7:0]  data_q;

	// final tick of the strobe
	assign last_tick = cpu_tick_i && (tick_cnt == WRITE_TICKS - 3'd1);

	//////////////////////////////
	// bus claim
	//////////////////////////////

	// chipset gives the bus to us for the whole download
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire)
			ext_req_q <= 1'b0;
		else
			ext_req_q <= download_i;
	end

	//////////////////////////////
	// write cycle FSM
	//////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			state     <= ST_IDLE;
			tick_cnt  <= 3'd0;
			write_n_q <= 1'b1;
			addr_q    <= 20'hFFFFF;
			data_q    <= 8'hFF;
		end
		else begin
			case (state)
				ST_IDLE: begin
					tick_cnt <= 3'd0;
					if (req_i.valid) begin
						// start the strobe, address and data held through it
						write_n_q <= 1'b0;
						addr_q    <= req_i.addr;
						data_q    <= req_i.data;
						state     <= ST_STROBE;
					end
				end
				ST_STROBE: begin
					// new requests ignored in here
					// download_i dropping does not cut the cycle short
					if (last_tick) begin
						write_n_q <= 1'b1;
						addr_q    <= 20'hFFFFF;
						data_q    <= 8'hFF;
						tick_cnt  <= 3'd0;
						state     <= ST_IDLE;
					end
					else if (cpu_tick_i) begin
						tick_cnt <= tick_cnt + 3'd1;
					end
				end
				default: begin
					state     <= ST_IDLE;
					write_n_q <= 1'b1;
				end
			endcase
		end
	end

	assign ext_access_request_o = ext_req_q;
	assign mem_write_n_o        = write_n_q;
	// idle value is all ones, like a floating bus
	assign bus_addr_o           = addr_q;
	assign bus_data_o           = data_q;

endmodule

// ==== source/cpu_clock_select.sv ====
`timescale 1ns/100ps

module cpu_clock_select (
	input  logic                       clk_chipset,
	input  logic                       reset_wire,
	input  logic                       sys_reset_i,
	input  pcxt_loader_pkg::cpu_speed_e speed_i,
	output logic                       cpu_tick_o
);

	import pcxt_loader_pkg::*;

	logic [7:0] div_sel;
	logic [7:0] cnt;
	logic       tick_q;

	//////////////////////////////
	// divisor select
	//////////////////////////////

	// 14.318 / 3, 14.318 / 2, 14.318 at the 50 MHz chipset clock
	always_comb begin
		case (speed_i)
			SPEED_7M16: div_sel = DIV_7M16;
			SPEED_14M3: div_sel = DIV_14M3;
			// code 3 too
			default:    div_sel = DIV_4M77;
		endcase
	end

	//////////////////////////////
	// tick counter
	//////////////////////////////

	// counts down to zero, tick on reload
	// new speed only picked up at the reload
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			cnt    <= DIV_4M77 - 8'd1;
			tick_q <= 1'b0;
		end
		else if (sys_reset_i) begin
			// quiet until the system is out of reset
			cnt    <= div_sel - 8'd1;
			tick_q <= 1'b0;
		end
		else if (cnt == 8'd0) begin
			cnt    <= div_sel - 8'd1;
			tick_q <= 1'b1;
		end
		else begin
			cnt    <= cnt - 8'd1;
			tick_q <= 1'b0;
		end
	end

	// one chipset cycle wide
	assign cpu_tick_o = tick_q;

endmodule

// ==== source/ioctl_decode.sv ====
`timescale 1ns/100ps

module ioctl_decode #(
	parameter int DL_ADDR_W = 25
) (
	input  logic                        clk_chipset,
	input  logic                        reset_wire,
	input  logic                        ioctl_wr_i,
	input  pcxt_loader_pkg::ioctl_byte_t ioctl_i,
	output pcxt_loader_pkg::bus_write_t  req_o
);

	import pcxt_loader_pkg::*;

	// upper download address bits select the image half
	localparam int HI_W = DL_ADDR_W - 16;

	logic [HI_W-1:0] addr_hi;
	logic            hit_bios;
	logic            hit_xtide;
	logic [19:0]     bus_addr;

	logic            valid_q;
	logic [19:0]     addr_q;
	logic [7:0]      data_q;

	assign addr_hi = ioctl_i.addr[DL_ADDR_W-1:16];

	//////////////////////////////
	// window decode
	//////////////////////////////

	// pcxt or tandy image in its first 64k
	assign hit_bios = (ioctl_i.index == IDX_BIOS_PCXT || ioctl_i.index == IDX_BIOS_TANDY) &&
		(addr_hi == '0);

	// xtide image or the second 64k of a pcxt download
	assign hit_xtide = (ioctl_i.index == IDX_XTIDE) ||
		(ioctl_i.index == IDX_BIOS_PCXT && addr_hi == HI_W'(1));

	// base keeps the top bits and download supplies the offset
	always_comb begin
		if (hit_bios)
			bus_addr = {BIOS_BASE[19:16], ioctl_i.addr[15:0]};
		else
			bus_addr = {XTIDE_BASE[19:14], ioctl_i.addr[13:0]};
	end

	// unmapped bytes are dropped here
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire)
			valid_q <= 1'b0;
		else
			valid_q <= ioctl_wr_i & (hit_bios | hit_xtide);
	end

	// payload only moves on a strobe
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			addr_q <= '0;
			data_q <= '0;
		end
		else if (ioctl_wr_i) begin
			addr_q <= bus_addr;
			data_q <= ioctl_i.data;
		end
	end

	assign req_o = '{valid: valid_q, addr: addr_q, data: data_q};

endmodule

// ==== source/pcxt_loader_pkg.sv ====
package pcxt_loader_pkg;

	//////////////////////////////
	// download and bus payloads
	//////////////////////////////

	// one byte from the download channel
	typedef struct packed {
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
	} ioctl_byte_t;

	// one decoded memory write, valid is a strobe
	typedef struct packed {
		logic        valid;
		logic [19:0] addr;
		logic [7:0]  data;
	} bus_write_t;

	// cpu rate, code 3 falls back to the slow rate
	typedef enum logic [1:0] {
		SPEED_4M77 = 2'd0,
		SPEED_7M16 = 2'd1,
		SPEED_14M3 = 2'd2
	} cpu_speed_e;

	//////////////////////////////
	// memory map
	//////////////////////////////

	// main bios window, 64k
	localparam logic [19:0] BIOS_BASE  = 20'hF0000;
	// disk bios window, 16k
	localparam logic [19:0] XTIDE_BASE = 20'hEC000;

	// download indexes
	localparam logic [7:0] IDX_BIOS_PCXT  = 8'd0;
	localparam logic [7:0] IDX_BIOS_TANDY = 8'd1;
	localparam logic [7:0] IDX_XTIDE      = 8'd2;

	// clk_chipset cycles per cpu tick
	localparam logic [7:0] DIV_4M77 = 8'd10;
	localparam logic [7:0] DIV_7M16 = 8'd7;
	localparam logic [7:0] DIV_14M3 = 8'd3;

	// write strobe length in cpu ticks
	localparam logic [2:0] WRITE_TICKS = 3'd4;

endpackage

// ==== source/pcxt_loader_top.sv ====
`timescale 1ns/100ps

module pcxt_loader_top #(
	parameter logic [15:0] RESET_HOLD      = 16'd65535,
	parameter logic [15:0] CPU_RESET_DELAY = 16'd42,
	parameter int          DL_ADDR_W       = 25
) (
	input  logic                         clk_chipset,
	input  logic                         reset_wire,

	// download channel
	input  logic                         download_i,
	input  logic                         ioctl_wr_i,
	input  pcxt_loader_pkg::ioctl_byte_t ioctl_i,

	// cpu rate
	input  pcxt_loader_pkg::cpu_speed_e  speed_i,

	// sound sources
	input  logic signed [15:0]           opl_i,
	input  logic                         speaker_i,
	input  logic [13:0]                  tandy_i,

	// system bus write side
	output logic                         ext_access_request_o,
	output logic                         mem_write_n_o,
	output logic [19:0]                  bus_addr_o,
	output logic [7:0]                   bus_data_o,

	// resets
	output logic                         sys_reset_o,
	output logic                         cpu_reset_o,

	// audio
	output logic [15:0]                  mix_o
);

	import pcxt_loader_pkg::*;

	bus_write_t req;
	logic       cpu_tick;

	//////////////////////////////
	// rom download path
	//////////////////////////////

	ioctl_decode #(
		.DL_ADDR_W (DL_ADDR_W)
	) u_ioctl_decode (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.ioctl_wr_i  (ioctl_wr_i),
		.ioctl_i     (ioctl_i),
		.req_o       (req)
	);

	// write timing follows the cpu rate
	cpu_clock_select u_cpu_clock_select (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.sys_reset_i (sys_reset_o),
		.speed_i     (speed_i),
		.cpu_tick_o  (cpu_tick)
	);

	bus_write_sequencer u_bus_write_sequencer (
		.clk_chipset          (clk_chipset),
		.reset_wire           (reset_wire),
		.download_i           (download_i),
		.req_i                (req),
		.cpu_tick_i           (cpu_tick),
		.ext_access_request_o (ext_access_request_o),
		.mem_write_n_o        (mem_write_n_o),
		.bus_addr_o           (bus_addr_o),
		.bus_data_o           (bus_data_o)
	);

	//////////////////////////////
	// system control
	//////////////////////////////

	reset_sequencer #(
		.RESET_HOLD      (RESET_HOLD),
		.CPU_RESET_DELAY (CPU_RESET_DELAY)
	) u_reset_sequencer (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.sys_reset_o (sys_reset_o),
		.cpu_reset_o (cpu_reset_o)
	);

	sound_mixer u_sound_mixer (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.opl_i       (opl_i),
		.speaker_i   (speaker_i),
		.tandy_i     (tandy_i),
		.mix_o       (mix_o)
	);

endmodule

// ==== source/reset_sequencer.sv ====
`timescale 1ns/100ps

module reset_sequencer #(
	parameter logic [15:0] RESET_HOLD      = 16'd65535,
	parameter logic [15:0] CPU_RESET_DELAY = 16'd42
) (
	input  logic clk_chipset,
	input  logic reset_wire,
	output logic sys_reset_o,
	output logic cpu_reset_o
);

	logic [15:0] sys_cnt;
	logic        sys_reset_q;
	logic [15:0] cpu_cnt;
	logic        cpu_reset_q;

	//////////////////////////////
	// system reset stretch
	//////////////////////////////

	// held RESET_HOLD cycles past the release of reset_wire
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			sys_reset_q <= 1'b1;
			sys_cnt     <= 16'd0;
		end
		else if (sys_reset_q) begin
			if (sys_cnt == RESET_HOLD - 16'd1)
				sys_reset_q <= 1'b0;
			else
				sys_cnt <= sys_cnt + 16'd1;
		end
	end

	//////////////////////////////
	// cpu reset delay
	//////////////////////////////

	// starts counting once sys_reset is low
	// lets the chipset settle before the cpu fetches
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_reset_q <= 1'b1;
			cpu_cnt     <= 16'd0;
		end
		else if (sys_reset_q) begin
			cpu_reset_q <= 1'b1;
			cpu_cnt     <= 16'd0;
		end
		else if (cpu_reset_q) begin
			if (cpu_cnt == CPU_RESET_DELAY - 16'd1)
				cpu_reset_q <= 1'b0;
			else
				cpu_cnt <= cpu_cnt + 16'd1;
		end
	end

	assign sys_reset_o = sys_reset_q;
	assign cpu_reset_o = cpu_reset_q;

endmodule

// ==== source/sound_mixer.sv ====
`timescale 1ns/100ps

module sound_mixer (
	input  logic               clk_chipset,
	input  logic               reset_wire,
	input  logic signed [15:0] opl_i,
	input  logic               speaker_i,
	input  logic [13:0]        tandy_i,
	output logic [15:0]        mix_o
);

	logic [16:0] opl_ext;
	logic [16:0] spk_term;
	logic [16:0] tandy_term;
	logic [16:0] sum;
	logic [15:0] mix_q;

	//////////////////////////////
	// source scaling
	//////////////////////////////

	// fm is signed, one extra sign bit
	assign opl_ext = {opl_i[15], opl_i};

	// speaker drives a fixed level when low
	assign spk_term = speaker_i ? 17'd0 : 17'd16384;

	// tone generator, x4
	assign tandy_term = {1'b0, tandy_i, 2'b00};

	// wraps in 17 bits
	assign sum = opl_ext + spk_term + tandy_term;

	//////////////////////////////
	// output register
	//////////////////////////////

	// halved to fit 16 bits
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire)
			mix_q <= 16'd0;
		else
			mix_q <= sum[16:1];
	end

	assign mix_o = mix_q;

endmodule
